// ==== files.f ====
source/core_pkg.sv
source/result_if.sv
source/pipe_stage.sv
source/register_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/core_top.sv
verif/core_assertions.sv
verif/core_checker.sv
verif/tb_core.sv

// ==== Bender.yml ====
package:
  name: core_pipe

sources:
  - source/core_pkg.sv
  - source/result_if.sv
  - source/pipe_stage.sv
  - source/register_file.sv
  - source/decode_unit.sv
  - source/execute_unit.sv
  - source/core_top.sv
  - target: test
    files:
      - verif/core_assertions.sv
      - verif/core_checker.sv
      - verif/tb_core.sv

// ==== verif/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

  localparam int in_timeout    = 200;
  localparam int drain_timeout = 500;

  typedef struct {
    int                                  test;
    int                                  gap;
    bit                                  reset_first;
    logic [core_pkg::instr_width-1:0]    instr;
    logic [core_pkg::reg_addr_width-1:0] dest;
    logic [core_pkg::data_width-1:0]     data;
  } row_t;

  logic                                clk;
  logic                                rst;
  logic                                in_valid;
  logic [core_pkg::instr_width-1:0]    in_instr;
  logic                                in_ready;
  logic                                wb_valid;
  logic                                wb_ready;
  logic [core_pkg::reg_addr_width-1:0] wb_dest;
  logic [core_pkg::data_width-1:0]     wb_data;

  row_t rows [$];
  int   seed        = 95210;
  int   cur_test    = 1;
  int   tests_total = 0;
  bit   hung        = 1'b0;

  core_top #(
    .num_regs (core_pkg::num_regs)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_ready (in_ready),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb_dest  (wb_dest),
    .wb_data  (wb_data)
  );

  core_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .in_ready (in_ready),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb_dest  (wb_dest),
    .wb_data  (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // consumer stalls about one cycle in four
  // held open while any test 1 beat is still due
  initial begin
    wb_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (cur_test <= 1 || u_checker.oldest_test() == 1) begin
        wb_ready = 1'b1;
      end else begin
        wb_ready = (($random(seed) & 3) != 0);
      end
    end
  end

  function automatic logic [core_pkg::instr_width-1:0] encode_reg(input logic [5:0] op,
      input int rd, input int rs, input int rt);
    return {op, 5'(rd), 5'(rs), 5'(rt), 11'd0};
  endfunction

  function automatic logic [core_pkg::instr_width-1:0] encode_imm(input logic [5:0] op,
      input int rd, input int rs, input logic [15:0] imm);
    return {op, 5'(rd), 5'(rs), imm};
  endfunction

  task automatic add_row(input int test, input int gap, input bit reset_first,
      input logic [core_pkg::instr_width-1:0] instr, input int dest,
      input logic [core_pkg::data_width-1:0] data);
    row_t r;
    r.test        = test;
    r.gap         = gap;
    r.reset_first = reset_first;
    r.instr       = instr;
    r.dest        = 5'(dest);
    r.data        = data;
    rows.push_back(r);
  endtask

  task automatic apply_row(input int idx);
    row_t r;
    bit   last;
    int   waited;
    r        = rows[idx];
    last     = (idx == rows.size() - 1) || (rows[idx + 1].test != r.test);
    cur_test = r.test;
    if (r.reset_first) begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
    end
    repeat (r.gap) begin
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_instr = r.instr;
    waited   = 0;
    @(negedge clk);
    while (!in_ready && waited < in_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("timeout: in_ready stayed low for %0d cycles in test %0d", in_timeout, r.test);
      hung = 1'b1;
    end else begin
      u_checker.expect_beat(r.test, last, r.dest, r.data);
      if (last) tests_total++;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (u_checker.pending_beats() != 0 && waited < drain_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (u_checker.pending_beats() != 0) begin
      $display("timeout: %0d writeback beats never arrived", u_checker.pending_beats());
      hung = 1'b1;
    end
    // extra cycles catch duplicated beats
    repeat (10) @(negedge clk);
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;

    // test, gap, reset first, instruction, expected dest, expected data
    add_row(1, 0, 0, encode_imm(core_pkg::op_addi, 1, 0, 16'd100), 1, 32'h0000_0064);
    add_row(1, 0, 0, encode_imm(core_pkg::op_addi, 2, 0, 16'hfff9), 2, 32'hffff_fff9);
    add_row(1, 0, 0, encode_imm(core_pkg::op_lui, 3, 0, 16'h1234), 3, 32'h1234_0000);
    add_row(1, 0, 0, encode_imm(core_pkg::op_addi, 12, 0, 16'd4), 12, 32'h0000_0004);
    add_row(1, 0, 0, encode_reg(core_pkg::op_add, 4, 1, 2), 4, 32'h0000_005d);
    add_row(1, 0, 0, encode_reg(core_pkg::op_sub, 5, 1, 2), 5, 32'h0000_006b);
    add_row(1, 0, 0, encode_reg(core_pkg::op_and, 6, 1, 2), 6, 32'h0000_0060);
    add_row(1, 0, 0, encode_reg(core_pkg::op_or, 7, 1, 3), 7, 32'h1234_0064);
    add_row(1, 0, 0, encode_reg(core_pkg::op_xor, 8, 1, 2), 8, 32'hffff_ff9d);
    add_row(1, 0, 0, encode_reg(core_pkg::op_slt, 9, 2, 1), 9, 32'h0000_0001);
    add_row(1, 0, 0, encode_reg(core_pkg::op_sll, 11, 1, 12), 11, 32'h0000_0640);
    // dependency chains
    add_row(2, 0, 0, encode_imm(core_pkg::op_addi, 13, 0, 16'd5), 13, 32'h0000_0005);
    add_row(2, 0, 0, encode_reg(core_pkg::op_add, 14, 13, 13), 14, 32'h0000_000a);
    add_row(2, 0, 0, encode_reg(core_pkg::op_sub, 15, 14, 13), 15, 32'h0000_0005);
    add_row(2, 0, 0, encode_reg(core_pkg::op_add, 16, 15, 14), 16, 32'h0000_000f);
    add_row(2, 0, 0, encode_reg(core_pkg::op_xor, 17, 16, 15), 17, 32'h0000_000a);
    add_row(2, 0, 0, encode_reg(core_pkg::op_sll, 18, 17, 13), 18, 32'h0000_0140);
    // r0, nop and an unknown opcode
    add_row(3, 0, 0, encode_imm(core_pkg::op_addi, 0, 0, 16'd55), 0, 32'h0000_0037);
    add_row(3, 0, 0, encode_reg(core_pkg::op_or, 19, 0, 1), 19, 32'h0000_0064);
    add_row(3, 0, 0, encode_reg(core_pkg::op_add, 20, 0, 0), 20, 32'h0000_0000);
    add_row(3, 0, 0, 32'h0000_0000, 0, 32'h0000_0000);
    add_row(3, 0, 0, encode_reg(6'h3f, 5, 1, 2), 0, 32'h0000_0000);
    // gaps on the input
    add_row(4, 2, 0, encode_imm(core_pkg::op_addi, 21, 1, 16'd28), 21, 32'h0000_0080);
    add_row(4, 0, 0, encode_reg(core_pkg::op_sll, 22, 21, 12), 22, 32'h0000_0800);
    add_row(4, 3, 0, encode_reg(core_pkg::op_sub, 23, 22, 21), 23, 32'h0000_0780);
    add_row(4, 0, 0, encode_reg(core_pkg::op_slt, 24, 23, 22), 24, 32'h0000_0001);
    add_row(4, 1, 0, encode_imm(core_pkg::op_lui, 25, 0, 16'hffff), 25, 32'hffff_0000);
    add_row(4, 0, 0, encode_reg(core_pkg::op_or, 26, 25, 23), 26, 32'hffff_0780);
    add_row(4, 2, 0, encode_reg(core_pkg::op_add, 27, 26, 24), 27, 32'hffff_0781);
    // reset with beats in flight then reads of cleared registers
    add_row(5, 0, 0, encode_imm(core_pkg::op_addi, 1, 0, 16'd7), 1, 32'h0000_0007);
    add_row(5, 0, 0, encode_reg(core_pkg::op_add, 2, 1, 1), 2, 32'h0000_000e);
    add_row(5, 0, 1, encode_reg(core_pkg::op_add, 4, 1, 2), 4, 32'h0000_0000);
    add_row(5, 0, 0, encode_imm(core_pkg::op_addi, 5, 3, 16'd9), 5, 32'h0000_0009);
    add_row(5, 0, 0, encode_reg(core_pkg::op_or, 7, 7, 5), 7, 32'h0000_0009);

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < rows.size() && !hung; i++) begin
      apply_row(i);
    end
    if (!hung) begin
      drain_pipeline();
    end
    u_checker.report_counts();
    if (!hung && u_checker.error_count == 0 && u_checker.fail_count == 0 &&
        u_checker.pass_count == tests_total) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/core_checker.sv ====
`timescale 1ns/1ps

module core_checker (
  input logic                                clk,
  input logic                                rst,
  input logic                                in_ready,
  input logic                                wb_valid,
  input logic                                wb_ready,
  input logic [core_pkg::reg_addr_width-1:0] wb_dest,
  input logic [core_pkg::data_width-1:0]     wb_data
);

  typedef struct {
    int                                  test;
    bit                                  last;
    logic [core_pkg::reg_addr_width-1:0] dest;
    logic [core_pkg::data_width-1:0]     data;
  } beat_t;

  beat_t expected [$];
  int    test_errors [16];
  int    pass_count  = 0;
  int    fail_count  = 0;
  int    error_count = 0;
  logic  rst_q       = 1'b0;

  task automatic expect_beat(input int test, input bit last,
      input logic [core_pkg::reg_addr_width-1:0] dest,
      input logic [core_pkg::data_width-1:0] data);
    beat_t b;
    b.test = test;
    b.last = last;
    b.dest = dest;
    b.data = data;
    expected.push_back(b);
  endtask

  function automatic int pending_beats();
    return expected.size();
  endfunction

  // test number of the oldest beat still due, 0 when none
  function automatic int oldest_test();
    if (expected.size() == 0) begin
      return 0;
    end
    return expected[0].test;
  endfunction

  task automatic report_counts();
    $display("tests passed: %0d, tests failed: %0d, other errors: %0d",
             pass_count, fail_count, error_count);
  endtask

  task automatic compare_beat();
    beat_t exp_beat;
    exp_beat = expected.pop_front();
    if (wb_dest !== exp_beat.dest) begin
      $display("Error at %0t: wb_dest is %0d, expected %0d", $time, wb_dest, exp_beat.dest);
      test_errors[exp_beat.test]++;
    end
    if (wb_data !== exp_beat.data) begin
      $display("Error at %0t: wb_data is %h, expected %h", $time, wb_data, exp_beat.data);
      test_errors[exp_beat.test]++;
    end
    if (exp_beat.last) begin
      if (test_errors[exp_beat.test] == 0) begin
        $display("test %0d passed", exp_beat.test);
        pass_count++;
      end else begin
        $display("test %0d failed with %0d errors", exp_beat.test, test_errors[exp_beat.test]);
        fail_count++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // sampled mid-cycle ahead of the transfer edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      // beats in flight are dropped by the reset
      expected.delete();
    end else begin
      if (rst_q && wb_valid !== 1'b0) begin
        $display("Error at %0t: wb_valid is %b, expected 0", $time, wb_valid);
        error_count++;
      end
      if (rst_q && in_ready !== 1'b1) begin
        $display("Error at %0t: in_ready is %b, expected 1", $time, in_ready);
        error_count++;
      end
      if (wb_valid && wb_ready) begin
        if (expected.size() == 0) begin
          $display("writeback beat to r%0d at %0t arrived with no instruction outstanding",
                   wb_dest, $time);
          error_count++;
        end else begin
          compare_beat();
        end
      end
    end
    rst_q <= rst;
  end

endmodule

// ==== verif/core_assertions.sv ====
`timescale 1ns/1ps

module core_assertions (
  input logic                                clk,
  input logic                                rst,
  input logic                                in_ready,
  input logic                                wb_valid,
  input logic                                wb_ready,
  input logic [core_pkg::reg_addr_width-1:0] wb_dest,
  input logic [core_pkg::data_width-1:0]     wb_data
);

  // stalled beat holds still
  wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb_dest) && $stable(wb_data))
    else $error("writeback beat changed while stalled");

  in_ready_open: assert property (@(posedge clk) disable iff (rst)
    wb_ready |-> in_ready)
    else $error("in_ready low while wb_ready high");

  wb_idle_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !wb_valid)
    else $error("wb_valid high right after reset");

endmodule

bind core_top core_assertions u_assertions (
  .clk      (clk),
  .rst      (rst),
  .in_ready (in_ready),
  .wb_valid (wb_valid),
  .wb_ready (wb_ready),
  .wb_dest  (wb_dest),
  .wb_data  (wb_data)
);

// ==== source/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter int num_regs = core_pkg::num_regs
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_valid,
  input  logic [core_pkg::instr_width-1:0]    in_instr,
  output logic                                in_ready,
  output logic                                wb_valid,
  input  logic                                wb_ready,
  output logic [core_pkg::reg_addr_width-1:0] wb_dest,
  output logic [core_pkg::data_width-1:0]     wb_data
);

  logic [core_pkg::reg_addr_width-1:0] rs;
  logic [core_pkg::reg_addr_width-1:0] rt;
  logic [core_pkg::data_width-1:0]     rs_data;
  logic [core_pkg::data_width-1:0]     rt_data;

  core_pkg::decoded_t dec;
  core_pkg::decoded_t dx_data;
  logic               dx_valid;
  logic               xw_ready;

  core_pkg::result_t  ex_result;
  core_pkg::result_t  xw_data;

  result_if wb_bus ();

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  decode_unit u_decode (
    .instr   (in_instr),
    .rs      (rs),
    .rt      (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .decoded (dec)
  );

  register_file #(
    .num_regs (num_regs)
  ) u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs      (rs),
    .rt      (rt),
    .wr      (wb_bus.sink),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  pipe_stage #(
    .payload_t (core_pkg::decoded_t)
  ) u_dx (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (in_valid),
    .data_in   (dec),
    .ready_in  (xw_ready),
    .ready_out (in_ready),
    .valid_out (dx_valid),
    .data_out  (dx_data)
  );

  //////////////////////////////////////////////////
  // execute and writeback
  //////////////////////////////////////////////////

  execute_unit u_execute (
    .decoded (dx_data),
    .fwd     (wb_bus.sink),
    .result  (ex_result)
  );

  pipe_stage #(
    .payload_t (core_pkg::result_t)
  ) u_xw (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (dx_valid),
    .data_in   (ex_result),
    .ready_in  (wb_bus.ready),
    .ready_out (xw_ready),
    .valid_out (wb_bus.valid),
    .data_out  (xw_data)
  );

  assign wb_bus.dest  = xw_data.dest;
  assign wb_bus.data  = xw_data.data;
  assign wb_bus.ready = wb_ready;

  assign wb_valid = wb_bus.valid;
  assign wb_dest  = wb_bus.dest;
  assign wb_data  = wb_bus.data;

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  core_pkg::decoded_t decoded,
  result_if.sink             fwd,
  output core_pkg::result_t  result
);

  localparam int shamt_width = $clog2(core_pkg::data_width);

  logic                            fwd_live;
  logic                            hit_a;
  logic                            hit_b;
  logic [core_pkg::data_width-1:0] op_a;
  logic [core_pkg::data_width-1:0] rt_val;
  logic [core_pkg::data_width-1:0] op_b;
  logic [core_pkg::data_width-1:0] alu_out;

  //////////////////////////////////////////////////
  // forwarding from the writeback stage
  //////////////////////////////////////////////////

  // u_xw always holds the direct predecessor here,
  // older results already sit in the regfile
  assign fwd_live = fwd.valid && (fwd.dest != '0);
  assign hit_a    = fwd_live && (fwd.dest == decoded.rs);
  assign hit_b    = fwd_live && (fwd.dest == decoded.rt);

  assign op_a   = hit_a ? fwd.data : decoded.operand_a;
  assign rt_val = hit_b ? fwd.data : decoded.operand_b;

  // immediate or register
  assign op_b = decoded.use_imm ? decoded.imm : rt_val;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  always_comb begin
    case (decoded.alu_op)
      core_pkg::alu_add: begin
        alu_out = op_a + op_b;
      end
      core_pkg::alu_sub: begin
        alu_out = op_a - op_b;
      end
      core_pkg::alu_and: begin
        alu_out = op_a & op_b;
      end
      core_pkg::alu_or: begin
        alu_out = op_a | op_b;
      end
      core_pkg::alu_xor: begin
        alu_out = op_a ^ op_b;
      end
      core_pkg::alu_slt: begin
        // signed compare
        alu_out = ($signed(op_a) < $signed(op_b)) ? 'd1 : '0;
      end
      core_pkg::alu_sll: begin
        alu_out = op_a << op_b[shamt_width-1:0];
      end
      core_pkg::alu_pass_b: begin
        // lui, and nop with its zero immediate
        alu_out = op_b;
      end
      default: begin
        alu_out = '0;
      end
    endcase
  end

  assign result.dest = decoded.dest;
  assign result.data = alu_out;

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic [core_pkg::instr_width-1:0]    instr,
  output logic [core_pkg::reg_addr_width-1:0] rs,
  output logic [core_pkg::reg_addr_width-1:0] rt,
  input  logic [core_pkg::data_width-1:0]     rs_data,
  input  logic [core_pkg::data_width-1:0]     rt_data,
  output core_pkg::decoded_t                  decoded
);

  localparam int ext_width = core_pkg::data_width - core_pkg::imm_width;

  core_pkg::opcode_e                   opcode;
  core_pkg::alu_op_e                   alu_op;
  logic [core_pkg::reg_addr_width-1:0] rd;
  logic [core_pkg::imm_width-1:0]      imm_field;
  logic                                known;
  logic                                use_imm;

  //////////////////////////////////////////////////
  // field split
  //////////////////////////////////////////////////

  assign opcode    = core_pkg::opcode_e'(instr[core_pkg::opcode_lsb +: core_pkg::opcode_width]);
  assign rd        = instr[core_pkg::rd_lsb +: core_pkg::reg_addr_width];
  assign rs        = instr[core_pkg::rs_lsb +: core_pkg::reg_addr_width];
  assign rt        = instr[core_pkg::rt_lsb +: core_pkg::reg_addr_width];
  assign imm_field = instr[core_pkg::imm_lsb +: core_pkg::imm_width];

  //////////////////////////////////////////////////
  // opcode to controls
  //////////////////////////////////////////////////

  always_comb begin
    known   = 1'b1;
    use_imm = 1'b0;
    alu_op  = core_pkg::alu_pass_b;
    case (opcode)
      core_pkg::op_add: alu_op = core_pkg::alu_add;
      core_pkg::op_sub: alu_op = core_pkg::alu_sub;
      core_pkg::op_and: alu_op = core_pkg::alu_and;
      core_pkg::op_or:  alu_op = core_pkg::alu_or;
      core_pkg::op_xor: alu_op = core_pkg::alu_xor;
      core_pkg::op_slt: alu_op = core_pkg::alu_slt;
      core_pkg::op_sll: alu_op = core_pkg::alu_sll;
      core_pkg::op_addi: begin
        alu_op  = core_pkg::alu_add;
        use_imm = 1'b1;
      end
      core_pkg::op_lui: use_imm = 1'b1;
      // nop and anything unknown: pass a zero immediate to r0
      default: begin
        known   = 1'b0;
        use_imm = 1'b1;
      end
    endcase
  end

  always_comb begin
    decoded.alu_op    = alu_op;
    decoded.use_imm   = use_imm;
    decoded.dest      = known ? rd : '0;
    decoded.rs        = rs;
    decoded.rt        = rt;
    decoded.operand_a = rs_data;
    decoded.operand_b = rt_data;
    if (opcode == core_pkg::op_addi) begin
      decoded.imm = {{ext_width{imm_field[core_pkg::imm_width-1]}}, imm_field};
    end else if (opcode == core_pkg::op_lui) begin
      decoded.imm = {imm_field, {ext_width{1'b0}}};
    end else begin
      decoded.imm = '0;
    end
  end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
  parameter int num_regs = core_pkg::num_regs
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [core_pkg::reg_addr_width-1:0] rs,
  input  logic [core_pkg::reg_addr_width-1:0] rt,
  result_if.sink                              wr,
  output logic [core_pkg::data_width-1:0]     rs_data,
  output logic [core_pkg::data_width-1:0]     rt_data
);

  logic [core_pkg::data_width-1:0] regs [num_regs];
  logic                            wr_en;

  // r0 is never written
  assign wr_en = wr.valid && wr.ready && (wr.dest != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.dest] <= wr.data;
    end
  end

  //////////////////////////////////////////////////
  // read ports, same-cycle write passes through
  //////////////////////////////////////////////////

  assign rs_data = (rs == '0)                  ? '0 :
                   (wr_en && (wr.dest == rs))  ? wr.data :
                                                 regs[rs];

  assign rt_data = (rt == '0)                  ? '0 :
                   (wr_en && (wr.dest == rt))  ? wr.data :
                                                 regs[rt];

endmodule

// ==== source/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_in,
  input  payload_t data_in,
  input  logic     ready_in,
  output logic     ready_out,
  output logic     valid_out,
  output payload_t data_out
);

  logic load;

  // take a new beat when empty or when the held one leaves
  assign ready_out = !valid_out || ready_in;
  assign load      = valid_in && ready_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (load) begin
      data_out <= data_in;
    end
  end

endmodule

// ==== source/result_if.sv ====
`timescale 1ns/1ps

// writeback result stream, also the regfile write port
interface result_if;
  logic                                valid;
  logic                                ready;
  logic [core_pkg::reg_addr_width-1:0] dest;
  logic [core_pkg::data_width-1:0]     data;

  modport source (
    output valid,
    output dest,
    output data,
    input  ready
  );

  modport sink (
    input valid,
    input ready,
    input dest,
    input data
  );
endinterface

// ==== source/core_pkg.sv ====
package core_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int data_width     = 32;
  localparam int instr_width    = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs       = 32;

  localparam int opcode_width = 6;
  localparam int imm_width    = 16;

  // low bit of each instruction field
  localparam int opcode_lsb = 26;
  localparam int rd_lsb     = 21;
  localparam int rs_lsb     = 16;
  localparam int rt_lsb     = 11;
  localparam int imm_lsb    = 0;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  typedef enum logic [opcode_width-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_addi = 6'd8,
    op_lui  = 6'd9
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_slt    = 4'd5,
    alu_sll    = 4'd6,
    alu_pass_b = 4'd7
  } alu_op_e;

  //////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////

  // decode to execute
  typedef struct packed {
    alu_op_e                   alu_op;
    logic                      use_imm;
    logic [reg_addr_width-1:0] dest;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [data_width-1:0]     operand_a;
    logic [data_width-1:0]     operand_b;
    logic [data_width-1:0]     imm;
  } decoded_t;

  // execute to writeback
  typedef struct packed {
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     data;
  } result_t;

endpackage
